/* rtl/fetch_cfg_pkg.sv */
`default_nettype none

package fetch_cfg_pkg;

    // --------------------
    // datapath widths
    // --------------------

    // instruction and data word
    localparam int WORD_W = 32;

    // pc and fetch address
    localparam int ADDR_W = 32;

    // --------------------
    // program memory
    // --------------------

    // default depth in words, instr_mem can be built with others
    localparam int MEM_DEPTH = 1024;

    // opcode field sits in the top bits of the word
    localparam int OPCODE_W = 6;

    // all-ones opcode stops the fetch stream
    localparam logic [OPCODE_W-1:0] HALT_OPCODE = 6'b111111;

    // retired-fetch counter width
    localparam int CNT_W = 16;

endpackage

`default_nettype wire

/* rtl/fetch_counter.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_counter (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_restart,
    input  logic                             i_fetch_en,
    output logic [fetch_cfg_pkg::CNT_W-1:0]  o_count
);

    import fetch_cfg_pkg::*;

    // ceiling, the count sticks here instead of wrapping
    localparam logic [CNT_W-1:0] CNT_MAX = '1;

    logic [CNT_W-1:0] count_q;

    // --------------------
    // count
    // --------------------

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            count_q <= '0;
        end else if (i_restart) begin
            // new run or step session
            count_q <= '0;
        end else if (i_fetch_en && (count_q != CNT_MAX)) begin
            count_q <= count_q + CNT_W'(1);
        end
    end

    assign o_count = count_q;

    // only restart may bring the count down
    a_count_monotonic : assert property (
        @(posedge i_clk) disable iff (!i_rst)
        !i_restart |=> (count_q >= $past(count_q)));

endmodule

`default_nettype wire

/* rtl/fetch_ctrl_pkg.sv */
`default_nettype none

package fetch_ctrl_pkg;

    // --------------------
    // run control
    // --------------------

    // idle after reset, halted after a halt word
    typedef enum logic [1:0] {
        S_IDLE    = 2'd0,
        S_RUN     = 2'd1,
        S_STEP    = 2'd2,
        S_HALTED  = 2'd3
    } run_state_t;

    // --------------------
    // bundles
    // --------------------

    // redirect from the later pipeline stages, jump wins over branch
    typedef struct packed {
        logic                             jump;
        logic [fetch_cfg_pkg::ADDR_W-1:0] jump_target;
        logic                             branch;
        logic [fetch_cfg_pkg::ADDR_W-1:0] branch_target;
    } redirect_t;

    // debug loader, one word per valid strobe
    typedef struct packed {
        logic                                          valid;
        logic [$clog2(fetch_cfg_pkg::MEM_DEPTH)-1:0]   addr;
        logic [fetch_cfg_pkg::WORD_W-1:0]              data;
    } load_t;

    // fetched word towards decode
    typedef struct packed {
        logic                             valid;
        logic [fetch_cfg_pkg::WORD_W-1:0] instruction;
        logic [fetch_cfg_pkg::ADDR_W-1:0] pc_plus1;
    } fetch_out_t;

endpackage

`default_nettype wire

/* rtl/fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module fetch_top (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  fetch_ctrl_pkg::load_t            i_load,
    input  logic                             i_start_run,
    input  logic                             i_start_step,
    input  logic                             i_step,
    input  fetch_ctrl_pkg::redirect_t        i_redirect,
    input  logic                             i_stall,
    output fetch_ctrl_pkg::fetch_out_t       o_fetch,
    output fetch_ctrl_pkg::run_state_t       o_state,
    output logic [fetch_cfg_pkg::CNT_W-1:0]  o_fetch_count
);

    import fetch_cfg_pkg::*;
    import fetch_ctrl_pkg::*;

    run_state_t        state;
    logic              fetch_en;
    logic              restart;
    logic              is_halt;
    logic              load_allow;
    logic [ADDR_W-1:0] fetch_addr;
    logic [ADDR_W-1:0] pc_plus1;
    logic [WORD_W-1:0] mem_data;

    // --------------------
    // control
    // --------------------

    run_control_fsm u_fsm (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_start_run  (i_start_run),
        .i_start_step (i_start_step),
        .i_step       (i_step),
        .i_is_halt    (is_halt),
        .o_state      (state),
        .o_fetch_en   (fetch_en),
        .o_restart    (restart)
    );

    fetch_counter u_counter (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_restart  (restart),
        .i_fetch_en (fetch_en),
        .o_count    (o_fetch_count)
    );

    // --------------------
    // datapath
    // --------------------

    pc_unit u_pc (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_restart    (restart),
        .i_fetch_en   (fetch_en),
        .i_redirect   (i_redirect),
        .i_stall      (i_stall),
        .i_is_halt    (is_halt),
        .o_fetch_addr (fetch_addr),
        .o_pc_plus1   (pc_plus1)
    );

    // loader only allowed while stopped
    assign load_allow = (state == S_IDLE) || (state == S_HALTED);

    instr_mem u_mem (
        .i_clk        (i_clk),
        .i_load       (i_load),
        .i_load_allow (load_allow),
        .i_addr       (fetch_addr),
        .o_data       (mem_data),
        .o_is_halt    (is_halt)
    );

    // valid follows the issued fetch
    assign o_fetch = '{valid: fetch_en, instruction: mem_data, pc_plus1: pc_plus1};
    assign o_state = state;

endmodule

`default_nettype wire

/* rtl/instr_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module instr_mem #(
    parameter int DEPTH = fetch_cfg_pkg::MEM_DEPTH
) (
    input  logic                             i_clk,
    input  fetch_ctrl_pkg::load_t            i_load,
    input  logic                             i_load_allow,
    input  logic [fetch_cfg_pkg::ADDR_W-1:0] i_addr,
    output logic [fetch_cfg_pkg::WORD_W-1:0] o_data,
    output logic                             o_is_halt
);

    import fetch_cfg_pkg::*;

    // index width, at least one bit for tiny memories
    localparam int IDX_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    logic [WORD_W-1:0] mem [DEPTH];
    logic [IDX_W-1:0]  wr_idx;
    logic [IDX_W-1:0]  rd_idx;
    logic              rd_in_range;
    logic [WORD_W-1:0] rd_data;

    // --------------------
    // loader write port
    // --------------------

    assign wr_idx = IDX_W'(i_load.addr);

    // only while stopped, running loads are dropped
    always_ff @(posedge i_clk) begin
        if (i_load.valid && i_load_allow) begin
            mem[wr_idx] <= i_load.data;
        end
    end

    // --------------------
    // read port
    // --------------------

    assign rd_idx      = i_addr[IDX_W-1:0];
    assign rd_in_range = (i_addr < ADDR_W'(DEPTH));

    // zero beyond the array
    assign rd_data = rd_in_range ? mem[rd_idx] : '0;

    assign o_data    = rd_data;
    assign o_is_halt = (rd_data[WORD_W-1 -: OPCODE_W] == HALT_OPCODE);

    // accepted loads must land inside the array
    a_load_in_range : assert property (
        @(posedge i_clk)
        (i_load.valid && i_load_allow) |-> (int'(i_load.addr) < DEPTH));

endmodule

`default_nettype wire

/* rtl/pc_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module pc_unit (
    input  logic                             i_clk,
    input  logic                             i_rst,
    input  logic                             i_restart,
    input  logic                             i_fetch_en,
    input  fetch_ctrl_pkg::redirect_t        i_redirect,
    input  logic                             i_stall,
    input  logic                             i_is_halt,
    output logic [fetch_cfg_pkg::ADDR_W-1:0] o_fetch_addr,
    output logic [fetch_cfg_pkg::ADDR_W-1:0] o_pc_plus1
);

    import fetch_cfg_pkg::*;

    logic [ADDR_W-1:0] pc_q;
    logic [ADDR_W-1:0] fetch_addr;
    logic [ADDR_W-1:0] pc_plus1;
    logic [ADDR_W-1:0] pc_next;

    // --------------------
    // fetch address
    // --------------------

    // jump, then branch, then the sequential pc
    always_comb begin
        if (i_redirect.jump) begin
            fetch_addr = i_redirect.jump_target;
        end else if (i_redirect.branch) begin
            fetch_addr = i_redirect.branch_target;
        end else begin
            fetch_addr = pc_q;
        end
    end

    // word addressed, so +1 is the next instruction
    assign pc_plus1 = fetch_addr + ADDR_W'(1);

    // --------------------
    // next pc
    // --------------------

    // stall or halt replays the fetch address
    assign pc_next = (i_stall || i_is_halt) ? fetch_addr : pc_plus1;

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            pc_q <= '0;
        end else if (i_restart) begin
            pc_q <= '0;
        end else if (i_fetch_en) begin
            pc_q <= pc_next;
        end
        // else hold, no fetch issued this cycle
    end

    assign o_fetch_addr = fetch_addr;
    assign o_pc_plus1   = pc_plus1;

endmodule

`default_nettype wire

/* rtl/run_control_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module run_control_fsm (
    input  logic                      i_clk,
    input  logic                      i_rst,
    input  logic                      i_start_run,
    input  logic                      i_start_step,
    input  logic                      i_step,
    input  logic                      i_is_halt,
    output fetch_ctrl_pkg::run_state_t o_state,
    output logic                      o_fetch_en,
    output logic                      o_restart
);

    import fetch_ctrl_pkg::*;

    run_state_t state_q;
    run_state_t state_d;
    logic       can_start;

    // --------------------
    // decode
    // --------------------

    // starts are only taken when nothing is executing
    assign can_start = (state_q == S_IDLE) || (state_q == S_HALTED);

    // restart pulses in the strobe cycle, pc and counter clear on that edge
    assign o_restart = can_start && (i_start_run || i_start_step);

    // free running in run mode, one fetch per step strobe otherwise
    assign o_fetch_en = (state_q == S_RUN) ||
                        ((state_q == S_STEP) && i_step);

    // --------------------
    // next state
    // --------------------

    always_comb begin
        state_d = state_q;
        if (o_restart) begin
            // run wins if both strobes land together
            if (i_start_run) begin
                state_d = S_RUN;
            end else begin
                state_d = S_STEP;
            end
        end else if (o_fetch_en && i_is_halt) begin
            // halt word was fetched, stop after this one
            state_d = S_HALTED;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    assign o_state = state_q;

    // --------------------
    // checks
    // --------------------

    // nothing is fetched in the cycle after a halt fetch
    a_halt_stops_fetch : assert property (
        @(posedge i_clk) disable iff (!i_rst)
        (o_fetch_en && i_is_halt) |=> !o_fetch_en);

    // restart lands in an executing state on the next edge
    a_restart_to_exec : assert property (
        @(posedge i_clk) disable iff (!i_rst)
        o_restart |=> (state_q inside {S_RUN, S_STEP}));

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_fetch_top -f sources.f -o sim_fetch_top

./obj_dir/sim_fetch_top | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi

echo "simulation finished without failures, see sim.log"

/* sources.f */
rtl/fetch_cfg_pkg.sv
rtl/fetch_ctrl_pkg.sv
rtl/run_control_fsm.sv
rtl/fetch_counter.sv
rtl/pc_unit.sv
rtl/instr_mem.sv
rtl/fetch_top.sv
verif/tb_clock_gen.sv
verif/tb_fetch_top.sv

/* verif/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst
);

    // 20 ns period
    localparam int HALF_PERIOD_NS = 10;
    localparam int RESET_CYCLES   = 8;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD_NS) o_clk = ~o_clk;
    end

    // active low, released on a falling edge
    initial begin
        o_rst = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst = 1'b1;
    end

endmodule

`default_nettype wire

/* verif/tb_fetch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fetch_top;

    import fetch_cfg_pkg::*;
    import fetch_ctrl_pkg::*;

    // program image, two halt words inside it
    localparam int PROG_AW    = 6;
    localparam int PROG_WORDS = 1 << PROG_AW;
    localparam int HALT_A     = 16;
    localparam int HALT_B     = 40;
    localparam int LOAD_AW    = $clog2(MEM_DEPTH);
    // ~200 cycles of tests, generous margin
    localparam int TIMEOUT_CYCLES = 4000;
    // sample well after the falling edge drive
    localparam int SAMPLE_DELAY   = 5;
    localparam logic [31:0] SEED  = 32'ha74ed9c9;
    // all-ones opcode in bits 31:26
    localparam logic [WORD_W-1:0] HALT_WORD = 32'hfc00_0000;
    localparam redirect_t NO_REDIRECT = '0;
    localparam load_t     NO_LOAD     = '0;

    logic              clk;
    logic              rst;
    load_t             load;
    logic              start_run;
    logic              start_step;
    logic              step;
    redirect_t         redirect;
    logic              stall;
    fetch_out_t        fetch;
    run_state_t        state;
    logic [CNT_W-1:0]  fetch_count;

    // reference model
    logic [WORD_W-1:0] model_mem [PROG_WORDS];
    logic [ADDR_W-1:0] model_pc;
    int                model_count;
    int                errors = 0;
    int                checks = 0;
    int                cycles = 0;

    tb_clock_gen u_clk_gen (
        .o_clk (clk),
        .o_rst (rst)
    );

    fetch_top u_dut (
        .i_clk         (clk),
        .i_rst         (rst),
        .i_load        (load),
        .i_start_run   (start_run),
        .i_start_step  (start_step),
        .i_step        (step),
        .i_redirect    (redirect),
        .i_stall       (stall),
        .o_fetch       (fetch),
        .o_state       (state),
        .o_fetch_count (fetch_count)
    );

    // --------------------
    // watchdog
    // --------------------

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    // --------------------
    // helpers
    // --------------------

    task automatic check(input logic [31:0] actual, input logic [31:0] expected,
                         input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t: %s, got %h expected %h", $time, msg, actual, expected);
        end
    endtask

    // opcode field in bits 31:26, all ones halts
    function automatic logic is_halt_word(input logic [WORD_W-1:0] w);
        return w[31:26] == 6'b111111;
    endfunction

    // random word that never carries the halt opcode
    function automatic logic [WORD_W-1:0] random_word();
        logic [WORD_W-1:0] w;
        w = $urandom;
        if (is_halt_word(w)) begin
            w[WORD_W-1] = 1'b0;
        end
        return w;
    endfunction

    function automatic logic [WORD_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
        if (addr < PROG_WORDS) begin
            return model_mem[addr[PROG_AW-1:0]];
        end
        return '0;
    endfunction

    task automatic idle_inputs();
        load       = '0;
        start_run  = 1'b0;
        start_step = 1'b0;
        step       = 1'b0;
        redirect   = '0;
        stall      = 1'b0;
    endtask

    // loader write while stopped, mirrored into the model
    task automatic load_word(input int addr, input logic [WORD_W-1:0] data);
        @(negedge clk);
        idle_inputs();
        load.valid = 1'b1;
        load.addr  = LOAD_AW'(addr);
        load.data  = data;
        model_mem[addr[PROG_AW-1:0]] = data;
    endtask

    // start strobe, pc and count restart at the next edge
    task automatic start_exec(input logic run);
        @(negedge clk);
        idle_inputs();
        start_run   = run;
        start_step  = !run;
        model_pc    = '0;
        model_count = 0;
    endtask

    // one cycle, checked against the model
    task automatic fetch_cycle(input redirect_t rd, input logic stall_in, input logic step_in,
                               input load_t ld, input logic exp_valid, output logic got_halt);
        logic [ADDR_W-1:0] addr;
        logic [WORD_W-1:0] word;
        @(negedge clk);
        idle_inputs();
        redirect = rd;
        stall    = stall_in;
        step     = step_in;
        load     = ld;
        #(SAMPLE_DELAY);
        // jump over branch over sequential
        if (rd.jump) begin
            addr = rd.jump_target;
        end else if (rd.branch) begin
            addr = rd.branch_target;
        end else begin
            addr = model_pc;
        end
        word     = model_read(addr);
        got_halt = 1'b0;
        check(32'(fetch.valid), 32'(exp_valid), "fetch valid");
        check(32'(fetch_count), 32'(model_count), "fetch count");
        if (exp_valid) begin
            check(fetch.instruction, word, $sformatf("instruction at %0d", addr));
            check(fetch.pc_plus1, addr + 32'd1, $sformatf("pc_plus1 at %0d", addr));
            got_halt = is_halt_word(word);
            model_count++;
            // stall or halt replays the address
            model_pc = (stall_in || got_halt) ? addr : addr + 32'd1;
        end
    endtask

    task automatic run_cycles(input int n);
        logic h;
        repeat (n) fetch_cycle(NO_REDIRECT, 1'b0, 1'b0, NO_LOAD, 1'b1, h);
    endtask

    // sequential fetches up to the halt, then one stopped cycle
    task automatic finish_at_halt(input int limit);
        logic h;
        int   n;
        h = 1'b0;
        n = 0;
        while (!h && n < limit) begin
            fetch_cycle(NO_REDIRECT, 1'b0, 1'b0, NO_LOAD, 1'b1, h);
            n++;
        end
        if (!h) begin
            errors++;
            $display("error: no halt word fetched within %0d cycles", limit);
        end
        fetch_cycle(NO_REDIRECT, 1'b0, 1'b0, NO_LOAD, 1'b0, h);
        check(32'(state), 32'(S_HALTED), "state after halt");
    endtask

    task automatic report(input string name, input int err_before);
        $display("test %s: %s, %0d errors", name,
                 (errors == err_before) ? "passed" : "failed", errors - err_before);
    endtask

    // --------------------
    // tests
    // --------------------

    task automatic test_load_and_run();
        int err0;
        err0 = errors;
        // outputs straight out of reset
        check(32'(state), 32'(S_IDLE), "state after reset");
        check(32'(fetch.valid), 32'd0, "fetch valid after reset");
        check(32'(fetch_count), 32'd0, "fetch count after reset");
        check(fetch.pc_plus1, 32'd1, "pc_plus1 after reset");
        for (int a = 0; a < PROG_WORDS; a++) begin
            load_word(a, (a == HALT_A || a == HALT_B) ? HALT_WORD : random_word());
        end
        start_exec(1'b1);
        finish_at_halt(32);
        check(32'(fetch_count), HALT_A + 1, "fetch count at halt");
        report("load and sequential run", err0);
    endtask

    task automatic test_redirect();
        redirect_t rd;
        logic      h;
        int        err0;
        err0 = errors;
        start_exec(1'b1);
        run_cycles(2);
        // branch alone
        rd               = '0;
        rd.branch        = 1'b1;
        rd.branch_target = 32'd20;
        fetch_cycle(rd, 1'b0, 1'b0, NO_LOAD, 1'b1, h);
        run_cycles(2);
        // jump beats branch
        rd.jump          = 1'b1;
        rd.jump_target   = 32'd30;
        rd.branch_target = 32'd25;
        fetch_cycle(rd, 1'b0, 1'b0, NO_LOAD, 1'b1, h);
        finish_at_halt(32);
        report("redirect priority", err0);
    endtask

    task automatic test_stall();
        logic h;
        int   err0;
        err0 = errors;
        start_exec(1'b1);
        run_cycles(3);
        repeat (3) fetch_cycle(NO_REDIRECT, 1'b1, 1'b0, NO_LOAD, 1'b1, h);
        finish_at_halt(32);
        report("stall", err0);
    endtask

    task automatic test_step();
        redirect_t rd;
        logic      h;
        logic      s;
        int        steps;
        int        err0;
        err0  = errors;
        steps = 0;
        start_exec(1'b0);
        // uneven step pattern
        for (int c = 0; c < 12; c++) begin
            s = (c % 3) != 1;
            fetch_cycle(NO_REDIRECT, 1'b0, s, NO_LOAD, s, h);
            if (s) begin
                steps++;
            end
        end
        fetch_cycle(NO_REDIRECT, 1'b0, 1'b0, NO_LOAD, 1'b0, h);
        check(32'(fetch_count), steps, "count after steps");
        check(32'(state), 32'(S_STEP), "state in step mode");
        // last step jumps onto the second halt
        rd             = '0;
        rd.jump        = 1'b1;
        rd.jump_target = HALT_B;
        fetch_cycle(rd, 1'b0, 1'b1, NO_LOAD, 1'b1, h);
        fetch_cycle(NO_REDIRECT, 1'b0, 1'b0, NO_LOAD, 1'b0, h);
        check(32'(state), 32'(S_HALTED), "state after step halt");
        report("step mode", err0);
    endtask

    task automatic test_load_gating();
        load_t ld;
        logic  h;
        int    err0;
        err0 = errors;
        start_exec(1'b1);
        run_cycles(2);
        // dropped by the memory, model keeps the old word
        ld       = '0;
        ld.valid = 1'b1;
        ld.addr  = LOAD_AW'(8);
        ld.data  = ~model_mem[8];
        fetch_cycle(NO_REDIRECT, 1'b0, 1'b0, ld, 1'b1, h);
        finish_at_halt(32);
        start_exec(1'b1);
        fetch_cycle(NO_REDIRECT, 1'b0, 1'b0, NO_LOAD, 1'b1, h);
        check(fetch.pc_plus1, 32'd1, "pc_plus1 after restart");
        finish_at_halt(32);
        report("load gating and restart", err0);
    endtask

    // --------------------
    // main sequence
    // --------------------

    initial begin
        void'($urandom(SEED));
        idle_inputs();
        model_pc    = '0;
        model_count = 0;
        @(posedge rst);
        test_load_and_run();
        test_redirect();
        test_stall();
        test_step();
        test_load_gating();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
